//--- src/hbus_pkg.sv
/*
  HyperRAM controller package
  Widths, device geometry, fixed latency, command/address layout
  and the PHY state encoding shared by the controller blocks
*/

package hbus_pkg;

  // Data and address widths
  localparam int WORD_W   = 16;
  localparam int SEL_W    = 2;
  localparam int ADDR_W   = 22;
  localparam int WB_ADR_W = 32;

  // Attached device and port count
  localparam int MEM_WORDS = 1024;
  localparam int NR_PORTS  = 2;

  // Initial latency in CK cycles, two clk_i cycles per CK cycle
  localparam int LATENCY_CK  = 6;
  localparam int LATENCY_CYC = 2 * LATENCY_CK;

  // Counter wide enough for the longest PHY phase
  localparam int CNT_W = $clog2(LATENCY_CYC);

  /*
    Command/address word, sent upper byte first
      47     read flag (1 = read)
      46     address space, 0 = memory
      45     burst type, 1 = linear
      44:16  word address bits 21..3, zero extended
      15:3   reserved, zero
      2:0    word address bits 2..0
  */
  localparam int CA_BYTES     = 6;
  localparam int CA_W         = CA_BYTES * 8;
  localparam int CA_RW_BIT    = 47;
  localparam int CA_AS_BIT    = 46;
  localparam int CA_BURST_BIT = 45;
  localparam int CA_ROW_MSB   = 44;
  localparam int CA_ROW_LSB   = 16;
  localparam int CA_ROW_W     = CA_ROW_MSB - CA_ROW_LSB + 1;
  localparam int CA_COL_W     = 3;

  // Upper byte of a word travels first on DQ
  typedef logic [WORD_W-1:0]           word_t;
  // Bit 1 enables the upper byte
  typedef logic [SEL_W-1:0]            sel_t;
  typedef logic [ADDR_W-1:0]           addr_t;
  typedef logic [WB_ADR_W-1:0]         wb_adr_t;
  typedef logic [CA_W-1:0]             ca_t;
  typedef logic [$clog2(NR_PORTS)-1:0] port_idx_t;

  typedef enum logic [2:0] {
    IDLE,
    CMD,
    LATENCY,
    WRITE,
    READ,
    DONE
  } phy_state_t;

endpackage

//--- src/hbus_req_if.sv
/*
  Word request interface
  Carries one 16-bit memory request and its completion from a
  requester to a responder
*/

`timescale 1ns/10ps

interface hbus_req_if import hbus_pkg::*; ();

  // Request side, held until done
  logic  valid;
  logic  we;
  addr_t addr;
  word_t wdata;
  sel_t  sel;

  // Response side, single-cycle pulses
  logic  grant;
  logic  done;
  word_t rdata;

  modport master (
    output valid, we, addr, wdata, sel,
    input  grant, done, rdata
  );

  modport slave (
    input  valid, we, addr, wdata, sel,
    output grant, done, rdata
  );

endinterface

//--- src/hbus_wb_port.sv
/*
  Wishbone classic slave port
  Range-checks the byte address, turns an accepted cycle into one
  word request, holds it until completion and answers with ack or err
*/

`timescale 1ns/10ps

module hbus_wb_port import hbus_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    wb_cyc_i,
  input  logic    wb_stb_i,
  input  logic    wb_we_i,
  input  wb_adr_t wb_adr_i,
  input  word_t   wb_dat_i,
  input  sel_t    wb_sel_i,
  output word_t   wb_dat_o,
  output logic    wb_ack_o,
  output logic    wb_err_o,
  hbus_req_if.master req
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_XFER,
    ST_RESP
  } port_state_t;

  port_state_t state_q;
  logic        cycle_start;
  logic        in_range;

  assign cycle_start = (state_q == ST_IDLE) && wb_cyc_i && wb_stb_i;
  // Two bytes per word, so the byte range is twice the word count
  assign in_range    = wb_adr_i < WB_ADR_W'(2 * MEM_WORDS);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= ST_IDLE;
      req.valid <= 1'b0;
      wb_ack_o  <= 1'b0;
      wb_err_o  <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (cycle_start) begin
            if (in_range) begin
              req.valid <= 1'b1;
              state_q   <= ST_REQ;
            end else begin
              wb_err_o <= 1'b1;
              state_q  <= ST_RESP;
            end
          end
        end
        // Waiting for the arbiter to hand over the PHY
        ST_REQ: begin
          if (req.grant) begin
            state_q <= ST_XFER;
          end
        end
        ST_XFER: begin
          if (req.done) begin
            req.valid <= 1'b0;
            wb_ack_o  <= 1'b1;
            state_q   <= ST_RESP;
          end
        end
        // Response cycle, stb is still up from the master here
        default: begin
          wb_ack_o <= 1'b0;
          wb_err_o <= 1'b0;
          state_q  <= ST_IDLE;
        end
      endcase
    end
  end

  // Request fields and read data
  always_ff @(posedge clk_i) begin
    if (cycle_start) begin
      req.we    <= wb_we_i;
      req.addr  <= wb_adr_i[ADDR_W:1];
      req.wdata <= wb_dat_i;
      req.sel   <= wb_sel_i;
    end
    if (state_q == ST_XFER && req.done) begin
      wb_dat_o <= req.rdata;
    end
  end

endmodule

//--- src/hbus_arbiter.sv
/*
  Round-robin arbiter
  Hands the PHY to one port per transaction, forwards the owner's
  request and routes grant and done back to that port only
*/

`timescale 1ns/10ps

module hbus_arbiter import hbus_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  hbus_req_if.slave  port_req [NR_PORTS],
  hbus_req_if.master phy_req
);

  logic [NR_PORTS-1:0] p_valid;
  logic [NR_PORTS-1:0] p_we;
  addr_t               p_addr  [NR_PORTS];
  word_t               p_wdata [NR_PORTS];
  sel_t                p_sel   [NR_PORTS];

  logic      busy_q;
  port_idx_t owner_q;
  port_idx_t last_q;
  port_idx_t rr_pick;
  port_idx_t cur;

  // Interface arrays cannot take a variable index, so flatten them
  for (genvar i = 0; i < NR_PORTS; i++) begin : g_port
    assign p_valid[i] = port_req[i].valid;
    assign p_we[i]    = port_req[i].we;
    assign p_addr[i]  = port_req[i].addr;
    assign p_wdata[i] = port_req[i].wdata;
    assign p_sel[i]   = port_req[i].sel;

    assign port_req[i].grant = phy_req.grant && (cur == port_idx_t'(i));
    assign port_req[i].done  = phy_req.done && busy_q && (owner_q == port_idx_t'(i));
    assign port_req[i].rdata = phy_req.rdata;
  end

  // Search starts at the port after the last winner
  always_comb begin
    int unsigned idx;
    logic        found;
    found   = 1'b0;
    rr_pick = last_q;
    for (int unsigned k = 1; k <= NR_PORTS; k++) begin
      idx = (int'(last_q) + k) % NR_PORTS;
      if (!found && p_valid[idx]) begin
        found   = 1'b1;
        rr_pick = port_idx_t'(idx);
      end
    end
  end

  assign cur = busy_q ? owner_q : rr_pick;

  assign phy_req.valid = busy_q ? p_valid[owner_q] : (|p_valid);
  assign phy_req.we    = p_we[cur];
  assign phy_req.addr  = p_addr[cur];
  assign phy_req.wdata = p_wdata[cur];
  assign phy_req.sel   = p_sel[cur];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q  <= 1'b0;
      owner_q <= '0;
      // Port 0 wins first
      last_q  <= port_idx_t'(NR_PORTS - 1);
    end else if (phy_req.grant) begin
      busy_q  <= 1'b1;
      owner_q <= rr_pick;
      last_q  <= rr_pick;
    end else if (phy_req.done) begin
      busy_q <= 1'b0;
    end
  end

endmodule

//--- src/hbus_phy.sv
/*
  HyperBus PHY
  Sends the 48-bit command/address, waits the fixed initial latency,
  then drives two write bytes with RWDS as byte mask or captures two
  read bytes on changes of RWDS. CK runs at half the clk_i rate
  while CS is low, and every pin is driven from a register
*/

`timescale 1ns/10ps

module hbus_phy import hbus_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  hbus_req_if.slave  req,
  output logic       hyper_cs_no,
  output logic       hyper_ck_o,
  output logic       hyper_ck_no,
  output logic [7:0] hyper_dq_o,
  input  logic [7:0] hyper_dq_i,
  output logic       hyper_dq_oe_o,
  output logic       hyper_rwds_o,
  output logic       hyper_rwds_oe_o,
  input  logic       hyper_rwds_i,
  output logic       hyper_reset_no
);

  phy_state_t       state_q;
  logic [CNT_W-1:0] cnt_q;
  ca_t              ca_cmd;
  ca_t              ca_q;
  word_t            rdata_q;
  logic             rwds_q;
  logic             rwds_edge;

  // Command/address built from the pending request
  always_comb begin
    ca_cmd                           = '0;
    ca_cmd[CA_RW_BIT]                = ~req.we;
    ca_cmd[CA_AS_BIT]                = 1'b0;
    ca_cmd[CA_BURST_BIT]             = 1'b1;
    ca_cmd[CA_ROW_MSB:CA_ROW_LSB]    = CA_ROW_W'(req.addr[ADDR_W-1:CA_COL_W]);
    ca_cmd[CA_COL_W-1:0]             = req.addr[CA_COL_W-1:0];
  end

  assign req.grant = (state_q == IDLE) && req.valid;
  assign req.done  = (state_q == DONE);
  assign req.rdata = rdata_q;

  // Device marks each read byte by flipping RWDS
  assign rwds_edge = hyper_rwds_i != rwds_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q         <= IDLE;
      cnt_q           <= '0;
      hyper_cs_no     <= 1'b1;
      hyper_ck_o      <= 1'b0;
      hyper_ck_no     <= 1'b1;
      hyper_dq_oe_o   <= 1'b0;
      hyper_rwds_o    <= 1'b0;
      hyper_rwds_oe_o <= 1'b0;
      hyper_reset_no  <= 1'b0;
    end else begin
      hyper_reset_no <= 1'b1;
      rwds_q         <= hyper_rwds_i;

      // CK toggles for as long as a transaction is on the bus
      if (state_q inside {CMD, LATENCY, WRITE, READ}) begin
        hyper_ck_o  <= ~hyper_ck_o;
        hyper_ck_no <= hyper_ck_o;
      end

      case (state_q)
        IDLE: begin
          if (req.grant) begin
            state_q       <= CMD;
            cnt_q         <= '0;
            hyper_cs_no   <= 1'b0;
            hyper_ck_o    <= 1'b1;
            hyper_ck_no   <= 1'b0;
            hyper_dq_o    <= ca_cmd[CA_W-1 -: 8];
            hyper_dq_oe_o <= 1'b1;
            ca_q          <= ca_cmd << 8;
          end
        end

        CMD: begin
          if (cnt_q == CNT_W'(CA_BYTES - 1)) begin
            state_q       <= LATENCY;
            cnt_q         <= '0;
            hyper_dq_o    <= 8'h00;
            // Reads hand DQ over to the device from here on
            hyper_dq_oe_o <= req.we;
          end else begin
            cnt_q      <= cnt_q + 1'b1;
            hyper_dq_o <= ca_q[CA_W-1 -: 8];
            ca_q       <= ca_q << 8;
          end
        end

        LATENCY: begin
          if (cnt_q == CNT_W'(LATENCY_CYC - 1)) begin
            cnt_q <= '0;
            if (req.we) begin
              state_q         <= WRITE;
              hyper_dq_o      <= req.wdata[15:8];
              hyper_rwds_o    <= ~req.sel[1];
              hyper_rwds_oe_o <= 1'b1;
            end else begin
              state_q <= READ;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end

        WRITE: begin
          if (cnt_q == '0) begin
            cnt_q        <= cnt_q + 1'b1;
            hyper_dq_o   <= req.wdata[7:0];
            hyper_rwds_o <= ~req.sel[0];
          end else begin
            state_q         <= DONE;
            hyper_cs_no     <= 1'b1;
            hyper_ck_o      <= 1'b0;
            hyper_ck_no     <= 1'b1;
            hyper_dq_oe_o   <= 1'b0;
            hyper_rwds_o    <= 1'b0;
            hyper_rwds_oe_o <= 1'b0;
          end
        end

        // Length depends on when the device starts toggling RWDS
        READ: begin
          if (rwds_edge) begin
            if (cnt_q == '0) begin
              cnt_q          <= cnt_q + 1'b1;
              rdata_q[15:8]  <= hyper_dq_i;
            end else begin
              rdata_q[7:0] <= hyper_dq_i;
              state_q      <= DONE;
              hyper_cs_no  <= 1'b1;
              hyper_ck_o   <= 1'b0;
              hyper_ck_no  <= 1'b1;
            end
          end
        end

        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

endmodule

//--- src/hbus_top.sv
/*
  HyperRAM controller top level
  Two Wishbone classic ports share one HyperBus PHY through a
  round-robin arbiter
*/

`timescale 1ns/10ps

module hbus_top import hbus_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  // Wishbone port 0
  input  logic       wb0_cyc_i,
  input  logic       wb0_stb_i,
  input  logic       wb0_we_i,
  input  wb_adr_t    wb0_adr_i,
  input  word_t      wb0_dat_i,
  input  sel_t       wb0_sel_i,
  output word_t      wb0_dat_o,
  output logic       wb0_ack_o,
  output logic       wb0_err_o,
  // Wishbone port 1
  input  logic       wb1_cyc_i,
  input  logic       wb1_stb_i,
  input  logic       wb1_we_i,
  input  wb_adr_t    wb1_adr_i,
  input  word_t      wb1_dat_i,
  input  sel_t       wb1_sel_i,
  output word_t      wb1_dat_o,
  output logic       wb1_ack_o,
  output logic       wb1_err_o,
  // HyperBus device pins
  output logic       hyper_cs_no,
  output logic       hyper_ck_o,
  output logic       hyper_ck_no,
  output logic [7:0] hyper_dq_o,
  input  logic [7:0] hyper_dq_i,
  output logic       hyper_dq_oe_o,
  output logic       hyper_rwds_o,
  output logic       hyper_rwds_oe_o,
  input  logic       hyper_rwds_i,
  output logic       hyper_reset_no
);

  hbus_req_if port_if [NR_PORTS] ();
  hbus_req_if phy_if ();

  hbus_wb_port u_port0 (
    .clk_i    ( clk_i      ),
    .rst_i    ( rst_i      ),
    .wb_cyc_i ( wb0_cyc_i  ),
    .wb_stb_i ( wb0_stb_i  ),
    .wb_we_i  ( wb0_we_i   ),
    .wb_adr_i ( wb0_adr_i  ),
    .wb_dat_i ( wb0_dat_i  ),
    .wb_sel_i ( wb0_sel_i  ),
    .wb_dat_o ( wb0_dat_o  ),
    .wb_ack_o ( wb0_ack_o  ),
    .wb_err_o ( wb0_err_o  ),
    .req      ( port_if[0] )
  );

  hbus_wb_port u_port1 (
    .clk_i    ( clk_i      ),
    .rst_i    ( rst_i      ),
    .wb_cyc_i ( wb1_cyc_i  ),
    .wb_stb_i ( wb1_stb_i  ),
    .wb_we_i  ( wb1_we_i   ),
    .wb_adr_i ( wb1_adr_i  ),
    .wb_dat_i ( wb1_dat_i  ),
    .wb_sel_i ( wb1_sel_i  ),
    .wb_dat_o ( wb1_dat_o  ),
    .wb_ack_o ( wb1_ack_o  ),
    .wb_err_o ( wb1_err_o  ),
    .req      ( port_if[1] )
  );

  hbus_arbiter u_arb (
    .clk_i    ( clk_i   ),
    .rst_i    ( rst_i   ),
    .port_req ( port_if ),
    .phy_req  ( phy_if  )
  );

  hbus_phy u_phy (
    .clk_i           ( clk_i           ),
    .rst_i           ( rst_i           ),
    .req             ( phy_if          ),
    .hyper_cs_no     ( hyper_cs_no     ),
    .hyper_ck_o      ( hyper_ck_o      ),
    .hyper_ck_no     ( hyper_ck_no     ),
    .hyper_dq_o      ( hyper_dq_o      ),
    .hyper_dq_i      ( hyper_dq_i      ),
    .hyper_dq_oe_o   ( hyper_dq_oe_o   ),
    .hyper_rwds_o    ( hyper_rwds_o    ),
    .hyper_rwds_oe_o ( hyper_rwds_oe_o ),
    .hyper_rwds_i    ( hyper_rwds_i    ),
    .hyper_reset_no  ( hyper_reset_no  )
  );

endmodule

//--- verif/hyperram_model.sv
/*
  Behavioral HyperRAM
  Decodes the command/address on CK changes while CS is low, applies
  RWDS-masked writes after the fixed latency and answers reads with
  one byte per CK change and RWDS toggling
*/

`timescale 1ns/10ps

module hyperram_model import hbus_pkg::*; (
  input  logic       hyper_cs_ni,
  input  logic       hyper_ck_i,
  input  logic [7:0] hyper_dq_i,
  output logic [7:0] hyper_dq_o,
  output logic       hyper_dq_oe_o,
  input  logic       hyper_rwds_i,
  output logic       hyper_rwds_o,
  output logic       hyper_rwds_oe_o
);

  // Sample point after each CK change, inside the 20 ns half period
  localparam int SAMPLE_DLY = 5;
  // First data byte follows the CA bytes and the initial latency
  localparam int DATA_EDGE  = CA_BYTES + 2 * LATENCY_CK + 1;

  word_t       mem [MEM_WORDS];
  ca_t         ca_q;
  logic        is_read;
  int unsigned idx;
  int unsigned edge_n;

  function automatic word_t fill_word(input int unsigned a);
    return word_t'(a * 257) ^ 16'hC3A5;
  endfunction

  task automatic on_edge(input int unsigned n);
    logic hi;
    hi = (n == DATA_EDGE);
    if (n <= CA_BYTES) begin
      ca_q = {ca_q[CA_W-9:0], hyper_dq_i};
      if (n == CA_BYTES) begin
        is_read = ca_q[CA_RW_BIT];
        idx     = int'({ca_q[CA_ROW_LSB +: ADDR_W-CA_COL_W], ca_q[CA_COL_W-1:0]}) % MEM_WORDS;
      end
    end else if (n == DATA_EDGE || n == DATA_EDGE + 1) begin
      if (is_read) begin
        hyper_dq_o      = hi ? mem[idx][15:8] : mem[idx][7:0];
        // RWDS flips once per byte, high for the upper byte
        hyper_rwds_o    = hi;
        hyper_dq_oe_o   = 1'b1;
        hyper_rwds_oe_o = 1'b1;
      end else if (!hyper_rwds_i) begin
        if (hi) begin
          mem[idx][15:8] = hyper_dq_i;
        end else begin
          mem[idx][7:0] = hyper_dq_i;
        end
      end
    end
  endtask

  initial begin : device
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(i);
    end
    hyper_dq_o      = '0;
    hyper_dq_oe_o   = 1'b0;
    hyper_rwds_o    = 1'b0;
    hyper_rwds_oe_o = 1'b0;
    forever begin
      @(negedge hyper_cs_ni);
      edge_n  = 0;
      ca_q    = '0;
      is_read = 1'b0;
      // The first CK rise comes together with the CS fall
      while (!hyper_cs_ni) begin
        edge_n++;
        #SAMPLE_DLY;
        on_edge(edge_n);
        @(hyper_ck_i or posedge hyper_cs_ni);
      end
      hyper_dq_oe_o   = 1'b0;
      hyper_rwds_oe_o = 1'b0;
    end
  end

endmodule

//--- verif/hbus_top_tb.sv
/*
  Testbench for the HyperRAM controller
  Applies a table of Wishbone accesses on both ports against the
  behavioral HyperRAM and compares results with a scoreboard
*/

`timescale 1ns/10ps

module hbus_top_tb import hbus_pkg::*; ();

  localparam int          CLK_HALF    = 20;
  localparam int          RST_CYCLES  = 16;
  localparam int          TIMEOUT_CYC = 200;
  localparam int          NR_STEPS    = 19;
  localparam logic [15:0] LFSR_SEED   = 16'd30938;

  typedef struct packed {
    logic    port;
    logic    we;
    logic    both;
    wb_adr_t adr;
    sel_t    sel;
    logic    exp_err;
  } step_t;

  logic                               clk_i;
  logic                               rst_i;
  logic [NR_PORTS-1:0]                cyc;
  logic [NR_PORTS-1:0]                stb;
  logic [NR_PORTS-1:0]                we;
  logic [NR_PORTS-1:0][WB_ADR_W-1:0]  adr;
  logic [NR_PORTS-1:0][WORD_W-1:0]    dat;
  logic [NR_PORTS-1:0][SEL_W-1:0]     sel;
  wire  [NR_PORTS-1:0][WORD_W-1:0]    dat_o;
  wire  [NR_PORTS-1:0]                ack;
  wire  [NR_PORTS-1:0]                err;

  wire        hyper_cs_no;
  wire        hyper_ck_o;
  wire        hyper_ck_no;
  wire  [7:0] hyper_dq_o;
  wire        hyper_dq_oe_o;
  wire        hyper_rwds_o;
  wire        hyper_rwds_oe_o;
  wire        hyper_reset_no;
  wire  [7:0] mdl_dq;
  wire        mdl_dq_oe;
  wire        mdl_rwds;
  wire        mdl_rwds_oe;
  wire  [7:0] dq_pad;
  wire        rwds_pad;

  step_t       steps [NR_STEPS];
  word_t       sb [MEM_WORDS];
  logic [15:0] lfsr_q;
  int          last_win;

  // Pads resolve to zero when neither side drives
  assign dq_pad   = hyper_dq_oe_o ? hyper_dq_o : (mdl_dq_oe ? mdl_dq : 8'h00);
  assign rwds_pad = hyper_rwds_oe_o ? hyper_rwds_o : (mdl_rwds_oe ? mdl_rwds : 1'b0);

  hbus_top u_hbus_top (
    .clk_i (clk_i), .rst_i (rst_i),
    .wb0_cyc_i (cyc[0]), .wb0_stb_i (stb[0]), .wb0_we_i (we[0]), .wb0_adr_i (adr[0]),
    .wb0_dat_i (dat[0]), .wb0_sel_i (sel[0]), .wb0_dat_o (dat_o[0]),
    .wb0_ack_o (ack[0]), .wb0_err_o (err[0]),
    .wb1_cyc_i (cyc[1]), .wb1_stb_i (stb[1]), .wb1_we_i (we[1]), .wb1_adr_i (adr[1]),
    .wb1_dat_i (dat[1]), .wb1_sel_i (sel[1]), .wb1_dat_o (dat_o[1]),
    .wb1_ack_o (ack[1]), .wb1_err_o (err[1]),
    .hyper_cs_no (hyper_cs_no), .hyper_ck_o (hyper_ck_o), .hyper_ck_no (hyper_ck_no),
    .hyper_dq_o (hyper_dq_o), .hyper_dq_i (dq_pad), .hyper_dq_oe_o (hyper_dq_oe_o),
    .hyper_rwds_o (hyper_rwds_o), .hyper_rwds_oe_o (hyper_rwds_oe_o),
    .hyper_rwds_i (rwds_pad), .hyper_reset_no (hyper_reset_no)
  );

  hyperram_model u_ram (
    .hyper_cs_ni (hyper_cs_no), .hyper_ck_i (hyper_ck_o), .hyper_dq_i (dq_pad),
    .hyper_dq_o (mdl_dq), .hyper_dq_oe_o (mdl_dq_oe), .hyper_rwds_i (rwds_pad),
    .hyper_rwds_o (mdl_rwds), .hyper_rwds_oe_o (mdl_rwds_oe)
  );

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_resp(input string name, input logic got_err, input logic exp_err);
    if (got_err !== exp_err) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s = %s, expected %s", $time, name,
                          got_err ? "err" : "ack", exp_err ? "err" : "ack"));
    end
  endtask

  task automatic check_pin(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, exp));
    end
  endtask

  // Bus parked with CS high, CK low and both enables off
  task automatic verify_bus_idle();
    check_pin("hyper_cs_no", hyper_cs_no, 1'b1);
    check_pin("hyper_ck_o", hyper_ck_o, 1'b0);
    check_pin("hyper_ck_no", hyper_ck_no, 1'b1);
    check_pin("hyper_dq_oe_o", hyper_dq_oe_o, 1'b0);
    check_pin("hyper_rwds_oe_o", hyper_rwds_oe_o, 1'b0);
  endtask

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_word(output word_t w);
    w = '0;
    for (int i = 0; i < WORD_W; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w      = {w[WORD_W-2:0], lfsr_q[0]};
    end
  endtask

  // Power-up contents of the memory model
  function automatic word_t fill_word(input int unsigned a);
    return word_t'(a * 257) ^ 16'hC3A5;
  endfunction

  function automatic word_t merge_word(input word_t old, input word_t nw, input sel_t s);
    return {s[1] ? nw[15:8] : old[15:8], s[0] ? nw[7:0] : old[7:0]};
  endfunction

  function automatic step_t make_step(input int p, input logic w, input logic b,
                                      input wb_adr_t a, input sel_t s, input logic e);
    step_t st;
    st.port    = p[0];
    st.we      = w;
    st.both    = b;
    st.adr     = a;
    st.sel     = s;
    st.exp_err = e;
    return st;
  endfunction

  task automatic start_cycle(input int p, input logic w, input wb_adr_t a,
                             input word_t d, input sel_t s);
    cyc[p] = 1'b1;
    stb[p] = 1'b1;
    we[p]  = w;
    adr[p] = a;
    dat[p] = d;
    sel[p] = s;
  endtask

  // Ends each active cycle on its own ack or err
  task automatic wait_resp(input logic [NR_PORTS-1:0] active,
                           output logic [NR_PORTS-1:0] got_err,
                           output logic [NR_PORTS-1:0][WORD_W-1:0] rdata);
    logic [NR_PORTS-1:0] pend;
    int                  cnt;
    pend    = active;
    got_err = '0;
    rdata   = '0;
    cnt     = 0;
    while (pend != '0) begin
      @(negedge clk_i);
      cnt++;
      for (int p = 0; p < NR_PORTS; p++) begin
        if (pend[p] && (ack[p] || err[p])) begin
          got_err[p] = err[p];
          rdata[p]   = dat_o[p];
          cyc[p]     = 1'b0;
          stb[p]     = 1'b0;
          we[p]      = 1'b0;
          pend[p]    = 1'b0;
        end
      end
      if (pend != '0 && cnt >= TIMEOUT_CYC) begin
        abort_run($sformatf("Timeout: no Wishbone ack or err within %0d cycles", TIMEOUT_CYC));
      end
    end
  endtask

  always @(negedge clk_i) begin
    if ((hyper_dq_oe_o && mdl_dq_oe) || (hyper_rwds_oe_o && mdl_rwds_oe)) begin
      abort_run("Bus contention between controller and memory model");
    end
  end

  initial begin : stimulus
    step_t                           st;
    logic [NR_PORTS-1:0]             got_err;
    logic [NR_PORTS-1:0][WORD_W-1:0] rdata;
    logic [NR_PORTS-1:0][WORD_W-1:0] wdata;
    int unsigned                     idx;
    int                              first;
    rst_i    = 1'b1;
    cyc      = '0;
    stb      = '0;
    we       = '0;
    adr      = '0;
    dat      = '0;
    sel      = '0;
    lfsr_q   = LFSR_SEED;
    last_win = NR_PORTS - 1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      sb[i] = fill_word(i);
    end
    //                    port we both adr       sel    err
    steps[0]  = make_step(0, 1, 0, 32'h0000_0010, 2'b11, 0);
    steps[1]  = make_step(0, 0, 0, 32'h0000_0010, 2'b11, 0);
    steps[2]  = make_step(1, 1, 0, 32'h0000_0100, 2'b11, 0);
    steps[3]  = make_step(1, 0, 0, 32'h0000_0100, 2'b11, 0);
    steps[4]  = make_step(0, 1, 0, 32'h0000_0010, 2'b01, 0);
    steps[5]  = make_step(0, 0, 0, 32'h0000_0010, 2'b11, 0);
    steps[6]  = make_step(1, 1, 0, 32'h0000_0100, 2'b10, 0);
    steps[7]  = make_step(1, 0, 0, 32'h0000_0100, 2'b11, 0);
    steps[8]  = make_step(0, 1, 0, 32'h0000_07FE, 2'b11, 0);
    steps[9]  = make_step(1, 0, 0, 32'h0000_07FE, 2'b11, 0);
    steps[10] = make_step(1, 1, 0, 32'h0000_0022, 2'b11, 0);
    steps[11] = make_step(0, 0, 0, 32'h0000_0022, 2'b11, 0);
    steps[12] = make_step(0, 1, 0, 32'h0000_0800, 2'b11, 1);
    steps[13] = make_step(1, 0, 0, 32'h0000_0800, 2'b11, 1);
    steps[14] = make_step(0, 0, 0, 32'h0000_0000, 2'b11, 0);
    steps[15] = make_step(1, 0, 0, 32'h0000_0010, 2'b11, 0);
    steps[16] = make_step(0, 1, 1, 32'h0000_0040, 2'b11, 0);
    steps[17] = make_step(0, 0, 0, 32'h0000_0040, 2'b11, 0);
    steps[18] = make_step(1, 0, 0, 32'h0000_0040, 2'b11, 0);

    repeat (RST_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    check_pin("hyper_reset_no", hyper_reset_no, 1'b0);
    rst_i = 1'b0;
    @(negedge clk_i);
    // Idle bus once reset is released
    verify_bus_idle();
    check_pin("hyper_reset_no", hyper_reset_no, 1'b1);

    for (int s = 0; s < NR_STEPS; s++) begin
      st  = steps[s];
      idx = int'(st.adr >> 1) % MEM_WORDS;
      @(negedge clk_i);
      if (st.both) begin
        take_word(wdata[0]);
        take_word(wdata[1]);
        start_cycle(0, 1'b1, st.adr, wdata[0], st.sel);
        start_cycle(1, 1'b1, st.adr, wdata[1], st.sel);
        wait_resp(2'b11, got_err, rdata);
        check_resp("wb0 response", got_err[0], 1'b0);
        check_resp("wb1 response", got_err[1], 1'b0);
        // The port after the last winner is served first
        first   = (last_win + 1) % NR_PORTS;
        sb[idx] = merge_word(sb[idx], wdata[first], st.sel);
        sb[idx] = merge_word(sb[idx], wdata[1 - first], st.sel);
        last_win = 1 - first;
      end else begin
        wdata = '0;
        if (st.we) begin
          take_word(wdata[st.port]);
        end
        start_cycle(st.port, st.we, st.adr, wdata[st.port], st.sel);
        wait_resp(2'b01 << st.port, got_err, rdata);
        check_resp($sformatf("wb%0d response", st.port), got_err[st.port], st.exp_err);
        if (!st.exp_err) begin
          last_win = st.port;
          if (st.we) begin
            sb[idx] = merge_word(sb[idx], wdata[st.port], st.sel);
          end else begin
            check_word($sformatf("wb%0d_dat_o", st.port), rdata[st.port], sb[idx]);
          end
        end
      end
      // CS rises in the DONE cycle, so the bus is parked by the response
      verify_bus_idle();
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- filelist.f
src/hbus_pkg.sv
src/hbus_req_if.sv
src/hbus_wb_port.sv
src/hbus_arbiter.sv
src/hbus_phy.sv
src/hbus_top.sv
verif/hyperram_model.sv
verif/hbus_top_tb.sv
